//--- common/fp_format_pkg.sv
package fp_format_pkg;

    // bfloat16-style word: 1 sign, 8 exponent, 7 fraction
    localparam int EXP_W  = 8;
    localparam int FRAC_W = 7;
    localparam int SIG_W  = FRAC_W + 1;   // with hidden one
    localparam int WORD_W = 1 + EXP_W + FRAC_W;

    localparam int EXP_BIAS = 127;

    localparam logic [EXP_W-1:0] EXP_MAX = '1;   // inf / nan exponent

    // canonical quiet nan payload
    localparam logic [FRAC_W-1:0] QNAN_FRAC = FRAC_W'(1);

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp_fields_t;

    // same word seen either as raw bits or as its fields
    typedef union packed {
        logic [WORD_W-1:0] raw;
        fp_fields_t        fields;
    } fp_word_u;

endpackage

//--- common/mult_ctrl_pkg.sv
package mult_ctrl_pkg;

    // encoding follows the round_mode pins
    typedef enum logic [1:0] {
        RND_NEAREST_EVEN = 2'd0,
        RND_ZERO         = 2'd1,
        RND_DOWN         = 2'd2,   // toward -inf
        RND_UP           = 2'd3    // toward +inf
    } round_mode_e;

    // oor[2] zero, oor[1] inf, oor[0] nan
    typedef struct packed {
        logic is_zero;
        logic is_inf;
        logic is_nan;
    } oor_flags_t;

    // start edge to done edge
    // SIG_W add-shift steps, mul_valid, two norm/round stages, output reg
    localparam int MULT_LATENCY = fp_format_pkg::SIG_W + 4;

endpackage

//--- common/fp_class_if.sv
`timescale 1ns/1ps

// operand class, latched at start and held until the next accepted start
interface fp_class_if ();

    logic is_nan;    // nan operand or 0 * inf
    logic is_inf;
    logic is_zero;
    logic sign;      // xor of operand signs

    modport src (
        output is_nan, is_inf, is_zero, sign
    );

    modport dst (
        input is_nan, is_inf, is_zero, sign
    );

endinterface

//--- common/fp_prod_if.sv
`timescale 1ns/1ps

// rounded finite result, one valid pulse per operation
interface fp_prod_if import fp_format_pkg::*; ();

    logic              valid;
    logic              sign;
    logic [EXP_W-1:0]  exp;        // final biased exponent
    logic [FRAC_W-1:0] frac;
    logic              overflow;   // biased exp reached EXP_MAX
    logic              underflow;  // biased exp at or below zero

    modport src (
        output valid, sign, exp, frac, overflow, underflow
    );

    modport dst (
        input valid, sign, exp, frac, overflow, underflow
    );

endinterface

//--- design/operand_classifier.sv
`timescale 1ns/1ps

module operand_classifier import fp_format_pkg::*; import mult_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  fp_word_u x,
    input  fp_word_u y,
    fp_class_if.src  cls
);

    localparam int CNT_W = $clog2(MULT_LATENCY);

    logic [CNT_W-1:0] busy_cnt;
    logic             accept;
    logic             x_nan, x_inf, x_zero;
    logic             y_nan, y_inf, y_zero;
    logic             pair_nan;

    assign accept = start && (busy_cnt == '0);   // starts while busy are dropped

    // exponent zero counts as zero
    assign x_zero = (x.fields.exp == '0);
    assign y_zero = (y.fields.exp == '0);
    assign x_inf  = (x.fields.exp == EXP_MAX) && (x.fields.frac == '0);
    assign y_inf  = (y.fields.exp == EXP_MAX) && (y.fields.frac == '0);
    assign x_nan  = (x.fields.exp == EXP_MAX) && (x.fields.frac != '0);
    assign y_nan  = (y.fields.exp == EXP_MAX) && (y.fields.frac != '0);

    assign pair_nan = x_nan || y_nan || (x_zero && y_inf) || (x_inf && y_zero);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy_cnt    <= '0;
            cls.is_nan  <= 1'b0;
            cls.is_inf  <= 1'b0;
            cls.is_zero <= 1'b0;
            cls.sign    <= 1'b0;
        end else begin
            if (accept) begin
                busy_cnt    <= CNT_W'(1);
                cls.is_nan  <= pair_nan;
                cls.is_inf  <= (x_inf || y_inf) && !pair_nan;
                cls.is_zero <= (x_zero || y_zero) && !pair_nan;
                cls.sign    <= x.fields.sign ^ y.fields.sign;
            end else if (busy_cnt != '0) begin
                // free again on the edge that registers done
                busy_cnt <= (busy_cnt == CNT_W'(MULT_LATENCY - 1)) ? '0 : busy_cnt + 1'b1;
            end
        end
    end

    // inf times zero must already have turned into nan
    a_class_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({cls.is_nan, cls.is_inf, cls.is_zero}));

    // class must hold for the whole operation
    a_class_stable: assert property (@(posedge clk) disable iff (reset)
        $changed({cls.is_nan, cls.is_inf, cls.is_zero, cls.sign}) |-> $past(start));

endmodule

//--- sig_datapath/shift_add_multiplier.sv
`timescale 1ns/1ps

module shift_add_multiplier import fp_format_pkg::*; #(
    parameter int WIDTH = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic [WIDTH-1:0]         sig_a,       // hidden one already attached
    input  logic [WIDTH-1:0]         sig_b,
    input  logic signed [EXP_W+1:0]  exp_sum_in,
    output logic                     busy,
    output logic                     mul_valid,
    output logic [2*WIDTH-1:0]       mul_product,
    output logic signed [EXP_W+1:0]  exp_sum
);

    // busy covers the whole operation so later stages never get overrun
    localparam int SPAN  = WIDTH + 4;
    localparam int CNT_W = $clog2(SPAN);

    logic [CNT_W-1:0]   cnt;
    logic [WIDTH-1:0]   mcand;
    logic [2*WIDTH-1:0] acc;        // upper half partial sum, lower half multiplier
    logic [WIDTH:0]     upper_sum;
    logic               accept;

    assign busy   = (cnt != '0);
    assign accept = start && !busy;

    // add multiplicand when the current multiplier bit is set
    assign upper_sum = {1'b0, acc[2*WIDTH-1:WIDTH]} + (acc[0] ? {1'b0, mcand} : '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt       <= '0;
            mul_valid <= 1'b0;
        end else begin
            mul_valid <= 1'b0;
            if (accept) begin
                cnt <= CNT_W'(1);
            end else if (busy) begin
                cnt <= (cnt == CNT_W'(SPAN - 1)) ? '0 : cnt + 1'b1;
            end
            if (cnt == CNT_W'(WIDTH + 1)) begin
                mul_valid <= 1'b1;   // all WIDTH steps done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            acc     <= {{WIDTH{1'b0}}, sig_b};
            mcand   <= sig_a;
            exp_sum <= exp_sum_in;   // travels with the product
        end else if (busy && (cnt <= CNT_W'(WIDTH))) begin
            acc <= {upper_sum, acc[WIDTH-1:1]};   // add then shift right
        end
    end

    assign mul_product = acc;

    a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
        mul_valid |=> !mul_valid);

    // set on edge WIDTH+1 after start, seen one sample later
    a_valid_timing: assert property (@(posedge clk) disable iff (reset)
        accept |-> ##(WIDTH + 2) mul_valid);

endmodule

//--- sig_datapath/norm_round.sv
`timescale 1ns/1ps

module norm_round import fp_format_pkg::*; import mult_ctrl_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    mul_valid,
    input  logic [2*SIG_W-1:0]      mul_product,
    input  logic signed [EXP_W+1:0] exp_sum,      // ex + ey, bias still in
    fp_class_if.dst                 cls,
    input  round_mode_e             round_mode,
    fp_prod_if.src                  prod
);

    // stage one signals
    logic                    top_bit;
    logic [SIG_W-1:0]        sig_trunc;
    logic                    guard;
    logic                    sticky;
    logic                    round_inc;
    logic signed [EXP_W+1:0] exp_norm;

    // stage one registers
    logic                    s1_valid;
    logic [SIG_W:0]          s1_sig;     // extra bit catches rounding carry
    logic signed [EXP_W+1:0] s1_exp;

    // stage two signals
    logic                    carry;
    logic signed [EXP_W+1:0] exp_fin;
    logic [FRAC_W-1:0]       frac_fin;

    // product of two 1.x values lies in [1, 4)
    always_comb begin
        top_bit = mul_product[2*SIG_W-1];
        if (top_bit) begin
            sig_trunc = mul_product[2*SIG_W-1 -: SIG_W];
            guard     = mul_product[SIG_W-1];
            sticky    = |mul_product[SIG_W-2:0];
        end else begin
            sig_trunc = mul_product[2*SIG_W-2 -: SIG_W];
            guard     = mul_product[SIG_W-2];
            sticky    = |mul_product[SIG_W-3:0];
        end

        exp_norm = exp_sum - (EXP_W+2)'(EXP_BIAS) + $signed({{(EXP_W+1){1'b0}}, top_bit});

        case (round_mode)
            RND_NEAREST_EVEN: round_inc = guard && (sticky || sig_trunc[0]);
            RND_ZERO:         round_inc = 1'b0;
            RND_DOWN:         round_inc = (guard || sticky) && cls.sign;
            default:          round_inc = (guard || sticky) && !cls.sign;   // toward +inf
        endcase
    end

    // carry out of rounding means the significand became 10.000..0
    assign carry    = s1_sig[SIG_W];
    assign exp_fin  = s1_exp + $signed({{(EXP_W+1){1'b0}}, carry});
    assign frac_fin = carry ? s1_sig[FRAC_W:1] : s1_sig[FRAC_W-1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid   <= 1'b0;
            prod.valid <= 1'b0;
        end else begin
            s1_valid   <= mul_valid;
            prod.valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_valid) begin
            s1_sig <= {1'b0, sig_trunc} + {{SIG_W{1'b0}}, round_inc};
            s1_exp <= exp_norm;
        end
        if (s1_valid) begin
            prod.sign      <= cls.sign;
            prod.exp       <= exp_fin[EXP_W-1:0];
            prod.frac      <= frac_fin;
            prod.overflow  <= (exp_fin >= $signed({2'b00, EXP_MAX}));
            prod.underflow <= (exp_fin <= 0);   // flush, no subnormals
        end
    end

endmodule

//--- design/result_assembler.sv
`timescale 1ns/1ps

module result_assembler import fp_format_pkg::*; import mult_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    fp_class_if.dst           cls,
    fp_prod_if.dst            prod,
    input  round_mode_e       round_mode,
    output logic [WORD_W-1:0] p,
    output oor_flags_t        oor,
    output logic              done
);

    fp_word_u   word;
    oor_flags_t flags;
    logic       to_inf;   // overflow rounds to inf, else to max finite

    always_comb begin
        case (round_mode)
            RND_NEAREST_EVEN: to_inf = 1'b1;
            RND_ZERO:         to_inf = 1'b0;
            RND_DOWN:         to_inf = prod.sign;
            default:          to_inf = !prod.sign;
        endcase
    end

    // special cases first, in priority order
    always_comb begin
        word.raw = '0;
        if (cls.is_nan) begin
            word.fields.sign = cls.sign;
            word.fields.exp  = EXP_MAX;
            word.fields.frac = QNAN_FRAC;
        end else if (cls.is_inf) begin
            word.fields.sign = cls.sign;
            word.fields.exp  = EXP_MAX;
        end else if (cls.is_zero || prod.underflow) begin
            word.fields.sign = cls.sign;   // signed zero
        end else if (prod.overflow) begin
            word.fields.sign = prod.sign;
            if (to_inf) begin
                word.fields.exp = EXP_MAX;
            end else begin
                word.fields.exp  = EXP_MAX - 1'b1;   // largest finite
                word.fields.frac = '1;
            end
        end else begin
            word.fields.sign = prod.sign;
            word.fields.exp  = prod.exp;
            word.fields.frac = prod.frac;
        end
    end

    assign flags.is_zero = (word.fields.exp == '0) && (word.fields.frac == '0);
    assign flags.is_inf  = (word.fields.exp == EXP_MAX) && (word.fields.frac == '0);
    assign flags.is_nan  = (word.fields.exp == EXP_MAX) && (word.fields.frac != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            p    <= '0;
            oor  <= '0;
            done <= 1'b0;
        end else begin
            done <= prod.valid;
            if (prod.valid) begin
                p   <= word.raw;   // held until the next result
                oor <= flags;
            end
        end
    end

    // one operation in flight, so done pulses are a full latency apart
    a_done_spacing: assert property (@(posedge clk) disable iff (reset)
        done |=> !done [*MULT_LATENCY-1]);

endmodule

//--- design/fp_mult_top.sv
`timescale 1ns/1ps

module fp_mult_top import fp_format_pkg::*; import mult_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [WORD_W-1:0] x,
    input  logic [WORD_W-1:0] y,
    input  logic [1:0]        round_mode,
    input  logic              start,
    output logic [WORD_W-1:0] p,
    output logic [2:0]        oor,
    output logic              done
);

    fp_class_if cls_if ();
    fp_prod_if  prod_if ();

    logic                    mul_busy;
    logic                    mul_valid;
    logic [2*SIG_W-1:0]      mul_product;
    logic signed [EXP_W+1:0] exp_sum;

    operand_classifier u_operand_classifier (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .x     (x),
        .y     (y),
        .cls   (cls_if.src)
    );

    // significands get their hidden one, exponents summed with bias intact
    shift_add_multiplier #(
        .WIDTH (SIG_W)
    ) u_shift_add_multiplier (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .sig_a       ({1'b1, x[FRAC_W-1:0]}),
        .sig_b       ({1'b1, y[FRAC_W-1:0]}),
        .exp_sum_in  ($signed({2'b00, x[WORD_W-2 -: EXP_W]}) +
                      $signed({2'b00, y[WORD_W-2 -: EXP_W]})),
        .busy        (mul_busy),
        .mul_valid   (mul_valid),
        .mul_product (mul_product),
        .exp_sum     (exp_sum)
    );

    norm_round u_norm_round (
        .clk         (clk),
        .reset       (reset),
        .mul_valid   (mul_valid),
        .mul_product (mul_product),
        .exp_sum     (exp_sum),
        .cls         (cls_if.dst),
        .round_mode  (round_mode_e'(round_mode)),
        .prod        (prod_if.src)
    );

    result_assembler u_result_assembler (
        .clk        (clk),
        .reset      (reset),
        .cls        (cls_if.dst),
        .prod       (prod_if.dst),
        .round_mode (round_mode_e'(round_mode)),
        .p          (p),
        .oor        (oor),
        .done       (done)
    );

    // done is registered on edge MULT_LATENCY and sampled one edge later
    a_start_to_done: assert property (@(posedge clk) disable iff (reset)
        (start && !mul_busy) |-> ##(MULT_LATENCY + 1) done);

endmodule

//--- bench/fp_mult_model.svh
`ifndef FP_MULT_MODEL_SVH
`define FP_MULT_MODEL_SVH

// uniform pick in [lo, hi] from the shared seed
function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
    int unsigned r;
    r = $unsigned($random(seed));
    return lo + (r % (hi - lo + 1));
endfunction

// normal operand with exponent in [lo_exp, hi_exp]
function automatic logic [15:0] rand_normal(input int unsigned lo_exp, input int unsigned hi_exp,
                                            input logic [6:0] frac_mask);
    logic [31:0] r;
    logic [7:0]  e;
    r = $random(seed);
    e = 8'(rand_range(lo_exp, hi_exp));
    return {r[0], e, r[7:1] & frac_mask};
endfunction

function automatic logic [15:0] rand_special();
    logic [31:0] r;
    int unsigned pick;
    r    = $random(seed);
    pick = rand_range(0, 4);
    case (pick)
        0: return {r[0], 8'hff, r[7:1] | 7'h01};   // nan, any payload
        1: return {r[0], 8'hff, 7'h00};            // inf
        2: return {r[0], 15'h0000};
        3: return {r[0], 8'h00, r[7:1]};           // exponent zero, fraction ignored
        default: return rand_normal(1, 254, 7'h7f);
    endcase
endfunction

// expected product word for one operation
function automatic logic [15:0] model_product(input logic [15:0] a, input logic [15:0] b,
                                              input logic [1:0] mode);
    logic        s;
    logic        a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;
    logic [15:0] full;
    logic [7:0]  keep;
    logic        g, st, up;
    logic [8:0]  rounded;
    int          e;
    s      = a[15] ^ b[15];
    a_zero = (a[14:7] == 8'h00);
    b_zero = (b[14:7] == 8'h00);
    a_inf  = (a[14:7] == 8'hff) && (a[6:0] == 7'h00);
    b_inf  = (b[14:7] == 8'hff) && (b[6:0] == 7'h00);
    a_nan  = (a[14:7] == 8'hff) && (a[6:0] != 7'h00);
    b_nan  = (b[14:7] == 8'hff) && (b[6:0] != 7'h00);
    if (a_nan || b_nan || (a_zero && b_inf) || (a_inf && b_zero))
        return {s, 8'hff, 7'h01};
    if (a_inf || b_inf)
        return {s, 8'hff, 7'h00};
    if (a_zero || b_zero)
        return {s, 15'h0000};
    full = {1'b1, a[6:0]} * {1'b1, b[6:0]};
    e    = int'(a[14:7]) + int'(b[14:7]) - 127;
    if (full[15]) begin
        keep = full[15:8];
        g    = full[7];
        st   = |full[6:0];
        e    = e + 1;
    end else begin
        keep = full[14:7];
        g    = full[6];
        st   = |full[5:0];
    end
    case (mode)
        2'd0: up = g && (st || keep[0]);   // ties go to even
        2'd1: up = 1'b0;
        2'd2: up = (g || st) && s;
        default: up = (g || st) && !s;
    endcase
    rounded = {1'b0, keep} + 9'(up);
    if (rounded[8]) begin
        keep = rounded[8:1];
        e    = e + 1;
    end else begin
        keep = rounded[7:0];
    end
    if (e <= 0)
        return {s, 15'h0000};
    if (e >= 255) begin
        case (mode)
            2'd0: return {s, 8'hff, 7'h00};
            2'd1: return {s, 8'hfe, 7'h7f};
            2'd2: return s ? {s, 8'hff, 7'h00} : {s, 8'hfe, 7'h7f};
            default: return s ? {s, 8'hfe, 7'h7f} : {s, 8'hff, 7'h00};
        endcase
    end
    return {s, e[7:0], keep[6:0]};
endfunction

// {is_zero, is_inf, is_nan}
function automatic logic [2:0] model_flags(input logic [15:0] w);
    return {w[14:0] == 15'h0000,
            (w[14:7] == 8'hff) && (w[6:0] == 7'h00),
            (w[14:7] == 8'hff) && (w[6:0] != 7'h00)};
endfunction

`endif

//--- bench/tb_fp_mult_top.sv
`timescale 1ns/1ps

module tb_fp_mult_top import mult_ctrl_pkg::*; ();

    localparam int NUM_DIRECTED = 32;
    localparam int NUM_RANDOM   = 600;
    localparam int CYCLE_LIMIT  = (NUM_DIRECTED + NUM_RANDOM) * (MULT_LATENCY + 3) + 100;

    logic        clk;
    logic        reset;
    logic [15:0] x;
    logic [15:0] y;
    logic [1:0]  round_mode;
    logic        start;
    logic [15:0] p;
    logic [2:0]  oor;
    logic        done;

    integer seed;
    int     cycle_count;

    `include "fp_mult_model.svh"

    fp_mult_top u_fp_mult_top (
        .clk        (clk),
        .reset      (reset),
        .x          (x),
        .y          (y),
        .round_mode (round_mode),
        .start      (start),
        .p          (p),
        .oor        (oor),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // one start, wait for done, compare; poke sends a start while busy
    task automatic run_op(input logic [15:0] a, input logic [15:0] b,
                          input logic [1:0] mode, input logic poke);
        logic [15:0] expect_p;
        int          waited;
        expect_p = model_product(a, b, mode);
        @(posedge clk);
        #2;
        x          = a;
        y          = b;
        round_mode = mode;   // held until done since the DUT does not latch it
        start      = 1'b1;
        @(posedge clk);
        #2;
        start  = 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            #1;
            if (waited > MULT_LATENCY + 2) begin
                $display("done did not arrive within %0d cycles of start", waited);
                $display("TEST FAILED");
                $fatal(1);
            end
            if (poke && waited == 4) begin
                #1;
                x     = $random(seed);
                y     = $random(seed);
                start = 1'b1;
            end
            if (poke && waited == 5) begin
                #1;
                start = 1'b0;
            end
        end while (!done);
        check_value("done latency", waited, MULT_LATENCY);
        check_value("p", p, expect_p);
        check_value("oor", oor, model_flags(expect_p));
    endtask

    initial begin
        int unsigned cat;
        logic [15:0] a;
        logic [15:0] b;
        logic [1:0]  mode;
        seed        = 32'h273fee9d;
        cycle_count = 0;
        reset       = 1'b1;
        start       = 1'b0;
        x           = '0;
        y           = '0;
        round_mode  = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        for (int m = 0; m < 4; m++) begin
            run_op(16'h3fb5, 16'h3fb5, 2'(m), 1'b0);   // rounds up to 2.0 in some modes
            run_op(16'h7f00, 16'h7f00, 2'(m), 1'b0);   // positive overflow
            run_op(16'hff00, 16'h7f00, 2'(m), 1'b0);   // negative overflow
            run_op(16'h0000, 16'h7f80, 2'(m), 1'b0);   // zero times inf
            run_op(16'h7fc0, 16'h3f80, 2'(m), 1'b0);
            run_op(16'hff80, 16'h4000, 2'(m), 1'b1);   // -inf * 2
            run_op(16'h8055, 16'h4000, 2'(m), 1'b0);   // exponent zero operand
            run_op(16'h0080, 16'h0080, 2'(m), 1'b0);   // underflow
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            cat  = rand_range(0, 7);
            mode = 2'($random(seed));
            case (cat)
                4: begin
                    // short fractions give exact halves
                    a = rand_normal(100, 154, 7'h78);
                    b = rand_normal(100, 154, 7'h78);
                end
                5: begin
                    a = rand_normal(180, 254, 7'h7f);
                    b = rand_normal(180, 254, 7'h7f);
                end
                6: begin
                    a = rand_normal(1, 70, 7'h7f);
                    b = rand_normal(1, 70, 7'h7f);
                end
                7: begin
                    a = rand_special();
                    b = rand_special();
                end
                default: begin
                    a = rand_normal(64, 190, 7'h7f);
                    b = rand_normal(64, 190, 7'h7f);
                end
            endcase
            run_op(a, b, mode, rand_range(0, 7) == 0);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- fp_mult_top.f
+incdir+bench
common/fp_format_pkg.sv
common/mult_ctrl_pkg.sv
common/fp_class_if.sv
common/fp_prod_if.sv
design/operand_classifier.sv
sig_datapath/shift_add_multiplier.sv
sig_datapath/norm_round.sv
design/result_assembler.sv
design/fp_mult_top.sv
bench/tb_fp_mult_top.sv

//--- Bender.yml
package:
  name: fp_mult_top

sources:
  - files:
      - common/fp_format_pkg.sv
      - common/mult_ctrl_pkg.sv
      - common/fp_class_if.sv
      - common/fp_prod_if.sv
      - design/operand_classifier.sv
      - sig_datapath/shift_add_multiplier.sv
      - sig_datapath/norm_round.sv
      - design/result_assembler.sv
      - design/fp_mult_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_fp_mult_top.sv
